// File: verilog/cx_consts.svh
// Width and CSR address constants of the CX dispatch unit, included wherever ports are sized
`ifndef CX_CONSTS_SVH
`define CX_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////////////////////

// Operands and result
`define CX_DATA_W 32
// Custom function field from decode
`define CX_FUNC_W 25
// CXU id and state id, each
`define CX_ID_W 2
`define CX_VSTATE_W 16
// Response flags ci, si, fi, op
`define CX_STATUS_W 4

////////////////////////////////////////////////////////////////////////////
// CSR map
////////////////////////////////////////////////////////////////////////////

`define CX_CSR_ADDR_W 12
`define CX_CSR_SELECTOR 12'h800
`define CX_CSR_STATUS 12'h801
`define CX_CSR_COUNT 12'h802

`endif

// File: verilog/cx_pkg.sv
// Shared types of the CX dispatch unit, imported by the CSR file, response capture and top level
`include "cx_consts.svh"

package cx_pkg;

  //////////////////////////////////////////////////////////////////////////
  // CSR addresses
  //////////////////////////////////////////////////////////////////////////

  typedef enum logic [`CX_CSR_ADDR_W-1:0] {
    CSR_SELECTOR = `CX_CSR_SELECTOR,
    CSR_STATUS   = `CX_CSR_STATUS,
    CSR_COUNT    = `CX_CSR_COUNT
  } cx_csr_e;

  //////////////////////////////////////////////////////////////////////////
  // Response status flags
  //////////////////////////////////////////////////////////////////////////

  // Listed MSB first, so ci lands on bit 0
  typedef struct packed {
    // Operation error
    logic op;
    // Function invalid
    logic fi;
    // State invalid
    logic si;
    // CXU invalid
    logic ci;
  } cx_status_t;

endpackage

// File: verilog/cx_issue.sv
// Request side of the CX unit: accepts decode issues, drives the request and tracks busy
`include "cx_consts.svh"

module cx_issue (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  // From decode
  input  logic                  issue_valid_i,
  input  logic [`CX_FUNC_W-1:0] issue_func_i,
  input  logic [`CX_DATA_W-1:0] issue_op_a_i,
  input  logic [`CX_DATA_W-1:0] issue_op_b_i,

  // Response strobe from the extension
  input  logic                  resp_valid_i,

  output logic                  busy_o,
  output logic                  resp_take_o,

  // Request to the extension
  output logic                  cx_req_valid_o,
  output logic [`CX_FUNC_W-1:0] cx_req_func_o,
  output logic [`CX_DATA_W-1:0] cx_req_data0_o,
  output logic [`CX_DATA_W-1:0] cx_req_data1_o
);

  logic                  accept;
  logic                  req_valid_q;
  logic                  active_q;
  logic                  active_n;
  logic [`CX_FUNC_W-1:0] req_func_q;
  logic [`CX_DATA_W-1:0] req_data0_q;
  logic [`CX_DATA_W-1:0] req_data1_q;

  // Issues while busy are dropped
  assign accept = issue_valid_i & ~active_q;

  // Response only counts while an operation is outstanding
  assign resp_take_o = resp_valid_i & active_q;

  // New operation starts, or the current one keeps running
  assign active_n = accept | (active_q & ~resp_valid_i);

  ////////////////////////////////////////////////////////////////////////////
  // Control state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      req_valid_q <= 1'b0;
      active_q    <= 1'b0;
    end else begin
      req_valid_q <= accept;
      active_q    <= active_n;
    end
  end

  // Payload held until the next accepted issue
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_func_q  <= issue_func_i;
      req_data0_q <= issue_op_a_i;
      req_data1_q <= issue_op_b_i;
    end
  end

  assign busy_o         = active_q;
  assign cx_req_valid_o = req_valid_q;
  assign cx_req_func_o  = req_func_q;
  assign cx_req_data0_o = req_data0_q;
  assign cx_req_data1_o = req_data1_q;

endmodule

// File: verilog/cx_csr_file.sv
// CX CSR file with selector, sticky status and completion count, read and written by the core
`include "cx_consts.svh"

module cx_csr_file (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // CSR access port
  input  logic                      csr_we_i,
  input  logic [`CX_CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [`CX_DATA_W-1:0]     csr_wdata_i,
  output logic [`CX_DATA_W-1:0]     csr_rdata_o,

  // Accepted response and its flags
  input  logic                      resp_take_i,
  input  cx_pkg::cx_status_t        resp_status_i,

  // Selector towards the extension
  output logic [`CX_ID_W-1:0]       cx_cxu_id_o,
  output logic [`CX_ID_W-1:0]       cx_state_id_o,
  output logic [`CX_VSTATE_W-1:0]   cx_virt_state_id_o
);

  import cx_pkg::*;

  localparam int unsigned SEL_PAD_W = `CX_DATA_W - `CX_VSTATE_W - 2 * `CX_ID_W;

  cx_csr_e                 csr_addr;
  logic                    sel_we;
  logic                    status_we;
  logic                    count_we;
  logic [`CX_ID_W-1:0]     cxu_id_q;
  logic [`CX_ID_W-1:0]     state_id_q;
  logic [`CX_VSTATE_W-1:0] vstate_id_q;
  cx_status_t              status_q;
  cx_status_t              status_n;
  cx_status_t              take_flags;
  logic [`CX_DATA_W-1:0]   count_q;
  logic [`CX_DATA_W-1:0]   count_n;
  logic [`CX_DATA_W-1:0]   sel_rdata;

  assign csr_addr = cx_csr_e'(csr_addr_i);

  // Write strobes per register, unknown addresses match none
  assign sel_we    = csr_we_i & (csr_addr == CSR_SELECTOR);
  assign status_we = csr_we_i & (csr_addr == CSR_STATUS);
  assign count_we  = csr_we_i & (csr_addr == CSR_COUNT);

  assign take_flags = resp_take_i ? resp_status_i : '0;

  ////////////////////////////////////////////////////////////////////////////
  // Next values
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Response flags are OR-ed onto a concurrent write
    if (status_we) begin
      status_n = cx_status_t'(csr_wdata_i[`CX_STATUS_W-1:0] | take_flags);
    end else begin
      status_n = cx_status_t'(status_q | take_flags);
    end
    if (count_we) begin
      count_n = csr_wdata_i + {{(`CX_DATA_W-1){1'b0}}, resp_take_i};
    end else begin
      count_n = count_q + {{(`CX_DATA_W-1){1'b0}}, resp_take_i};
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      cxu_id_q    <= '0;
      state_id_q  <= '0;
      vstate_id_q <= '0;
      status_q    <= '0;
      count_q     <= '0;
    end else begin
      if (sel_we) begin
        cxu_id_q    <= csr_wdata_i[`CX_ID_W-1:0];
        state_id_q  <= csr_wdata_i[2*`CX_ID_W-1:`CX_ID_W];
        vstate_id_q <= csr_wdata_i[`CX_DATA_W-1:`CX_DATA_W-`CX_VSTATE_W];
      end
      status_q <= status_n;
      count_q  <= count_n;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////////////////////

  // Virtual state id on top, the two ids at the bottom
  assign sel_rdata = {vstate_id_q, {SEL_PAD_W{1'b0}}, state_id_q, cxu_id_q};

  always_comb begin
    unique case (csr_addr)
      CSR_SELECTOR: csr_rdata_o = sel_rdata;
      CSR_STATUS:   csr_rdata_o = {{(`CX_DATA_W-`CX_STATUS_W){1'b0}}, status_q};
      CSR_COUNT:    csr_rdata_o = count_q;
      default:      csr_rdata_o = '0;
    endcase
  end

  assign cx_cxu_id_o        = cxu_id_q;
  assign cx_state_id_o      = state_id_q;
  assign cx_virt_state_id_o = vstate_id_q;

endmodule

// File: verilog/cx_resp_capture.sv
// Response side of the CX unit: registers accepted results and decodes the status flags
`include "cx_consts.svh"

module cx_resp_capture (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // Qualified response from the issue side
  input  logic                    resp_take_i,
  input  logic [`CX_DATA_W-1:0]   resp_data_i,
  input  logic [`CX_STATUS_W-1:0] resp_status_i,

  // Result towards the core
  output logic                    result_valid_o,
  output logic [`CX_DATA_W-1:0]   result_data_o,

  // Named flags for the status CSR
  output cx_pkg::cx_status_t      status_o
);

  import cx_pkg::*;

  logic                  result_valid_q;
  logic [`CX_DATA_W-1:0] result_data_q;

  ////////////////////////////////////////////////////////////////////////////
  // Result register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      result_valid_q <= 1'b0;
    end else begin
      result_valid_q <= resp_take_i;
    end
  end

  // Data held until the next accepted response
  always_ff @(posedge clk_i) begin
    if (resp_take_i) begin
      result_data_q <= resp_data_i;
    end
  end

  assign result_valid_o = result_valid_q;
  assign result_data_o  = result_data_q;

  // Flag order on the bus is ci, si, fi, op from bit 0
  assign status_o.ci = resp_status_i[0];
  assign status_o.si = resp_status_i[1];
  assign status_o.fi = resp_status_i[2];
  assign status_o.op = resp_status_i[3];

endmodule

// File: verilog/cx_unit_top.sv
// Top level of the standalone CX dispatch unit, connecting issue, CSR file and response capture
`include "cx_consts.svh"

module cx_unit_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // Custom instruction from decode
  input  logic                      issue_valid_i,
  input  logic [`CX_FUNC_W-1:0]     issue_func_i,
  input  logic [`CX_DATA_W-1:0]     issue_op_a_i,
  input  logic [`CX_DATA_W-1:0]     issue_op_b_i,
  output logic                      busy_o,

  // CX request
  output logic                      cx_req_valid_o,
  output logic [`CX_FUNC_W-1:0]     cx_req_func_o,
  output logic [`CX_DATA_W-1:0]     cx_req_data0_o,
  output logic [`CX_DATA_W-1:0]     cx_req_data1_o,
  output logic [`CX_ID_W-1:0]       cx_cxu_id_o,
  output logic [`CX_ID_W-1:0]       cx_state_id_o,
  output logic [`CX_VSTATE_W-1:0]   cx_virt_state_id_o,

  // CX response
  input  logic                      resp_valid_i,
  input  logic [`CX_DATA_W-1:0]     resp_data_i,
  input  logic [`CX_STATUS_W-1:0]   resp_status_i,

  // Result
  output logic                      result_valid_o,
  output logic [`CX_DATA_W-1:0]     result_data_o,

  // CSR port
  input  logic                      csr_we_i,
  input  logic [`CX_CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [`CX_DATA_W-1:0]     csr_wdata_i,
  output logic [`CX_DATA_W-1:0]     csr_rdata_o
);

  import cx_pkg::*;

  logic       resp_take;
  cx_status_t resp_status;

  cx_issue u_issue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .issue_valid_i  (issue_valid_i),
    .issue_func_i   (issue_func_i),
    .issue_op_a_i   (issue_op_a_i),
    .issue_op_b_i   (issue_op_b_i),
    .resp_valid_i   (resp_valid_i),
    .busy_o         (busy_o),
    .resp_take_o    (resp_take),
    .cx_req_valid_o (cx_req_valid_o),
    .cx_req_func_o  (cx_req_func_o),
    .cx_req_data0_o (cx_req_data0_o),
    .cx_req_data1_o (cx_req_data1_o)
  );

  cx_csr_file u_csr_file (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .csr_we_i           (csr_we_i),
    .csr_addr_i         (csr_addr_i),
    .csr_wdata_i        (csr_wdata_i),
    .csr_rdata_o        (csr_rdata_o),
    .resp_take_i        (resp_take),
    .resp_status_i      (resp_status),
    .cx_cxu_id_o        (cx_cxu_id_o),
    .cx_state_id_o      (cx_state_id_o),
    .cx_virt_state_id_o (cx_virt_state_id_o)
  );

  cx_resp_capture u_resp_capture (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .resp_take_i    (resp_take),
    .resp_data_i    (resp_data_i),
    .resp_status_i  (resp_status_i),
    .result_valid_o (result_valid_o),
    .result_data_o  (result_data_o),
    .status_o       (resp_status)
  );

endmodule

// File: verification/tb_clk_gen.sv
// Clock and active-low reset source for the CX unit testbench, instantiated by tb_cx_unit
module tb_clk_gen #(
  parameter int unsigned PERIOD_NS    = 10,
  parameter int unsigned RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release on a falling edge, clear of the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: verification/tb_cx_unit.sv
// Table-driven testbench of the CX dispatch unit, compiled through src.f with this module on top
`include "cx_consts.svh"

module tb_cx_unit;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned CLK_PERIOD_NS   = 10;
  localparam logic [31:0] LFSR_SEED       = 32'h0000_615d;
  localparam logic [31:0] LFSR_TAPS       = 32'h8020_0003;
  localparam int unsigned NUM_ROWS        = 22;
  // Twenty cycles per row plus room for reset
  localparam int unsigned WATCHDOG_CYCLES = NUM_ROWS * 20 + 50;

  typedef enum logic [2:0] {STEP_ISSUE, STEP_RESP, STEP_CSR_WR, STEP_CSR_RD, STEP_IDLE} step_e;

  // Expected pulse and busy level are sampled after the row's clock edge
  typedef struct packed {
    step_e                     kind;
    logic [`CX_CSR_ADDR_W-1:0] addr;
    logic [`CX_DATA_W-1:0]     data;
    logic                      exp_pulse;
    logic                      exp_busy;
    logic [`CX_DATA_W-1:0]     exp_val;
  } row_t;

  // DUT port signals
  logic                      clk_i;
  logic                      rst_ni;
  logic                      issue_valid_i;
  logic [`CX_FUNC_W-1:0]     issue_func_i;
  logic [`CX_DATA_W-1:0]     issue_op_a_i;
  logic [`CX_DATA_W-1:0]     issue_op_b_i;
  logic                      busy_o;
  logic                      cx_req_valid_o;
  logic [`CX_FUNC_W-1:0]     cx_req_func_o;
  logic [`CX_DATA_W-1:0]     cx_req_data0_o;
  logic [`CX_DATA_W-1:0]     cx_req_data1_o;
  logic [`CX_ID_W-1:0]       cx_cxu_id_o;
  logic [`CX_ID_W-1:0]       cx_state_id_o;
  logic [`CX_VSTATE_W-1:0]   cx_virt_state_id_o;
  logic                      resp_valid_i;
  logic [`CX_DATA_W-1:0]     resp_data_i;
  logic [`CX_STATUS_W-1:0]   resp_status_i;
  logic                      result_valid_o;
  logic [`CX_DATA_W-1:0]     result_data_o;
  logic                      csr_we_i;
  logic [`CX_CSR_ADDR_W-1:0] csr_addr_i;
  logic [`CX_DATA_W-1:0]     csr_wdata_i;
  logic [`CX_DATA_W-1:0]     csr_rdata_o;

  row_t                  rows [NUM_ROWS];
  string                 row_name [NUM_ROWS];
  int unsigned           n_rows;
  int unsigned           errors;
  logic [31:0]           lfsr_state;
  // Expected DUT state, updated only by rows that are accepted
  logic                  have_payload;
  logic                  have_result;
  logic [`CX_FUNC_W-1:0] exp_func;
  logic [`CX_DATA_W-1:0] exp_op_a;
  logic [`CX_DATA_W-1:0] exp_op_b;
  logic [`CX_DATA_W-1:0] exp_result;
  logic [`CX_DATA_W-1:0] sel_exp;

  tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(3)) u_clk_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  cx_unit_top UUT (.*);

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ LFSR_TAPS;
    end
    return state >> 1;
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int unsigned nbits, output logic [31:0] value);
    value = '0;
    for (int unsigned b = 0; b < nbits; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
  endtask

  task automatic report_mismatch(input string test, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
    $display("Error in %s, %s: expected %h, actual %h", test, what, expected, actual);
    errors++;
  endtask

  task automatic add_row(input step_e kind, input string name,
                         input logic [`CX_CSR_ADDR_W-1:0] addr, input logic [31:0] data,
                         input logic exp_pulse, input logic exp_busy, input logic [31:0] exp_val);
    if (n_rows < NUM_ROWS) begin
      rows[n_rows]     = '{kind, addr, data, exp_pulse, exp_busy, exp_val};
      row_name[n_rows] = name;
    end
    n_rows++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////

  // Response rows carry the raw flags ci, si, fi, op from bit 0 in data
  task automatic build_table();
    add_row(STEP_CSR_RD, "reset_selector", `CX_CSR_SELECTOR, 32'h0, 1'b0, 1'b0, 32'h0);
    add_row(STEP_CSR_RD, "reset_status", `CX_CSR_STATUS, 32'h0, 1'b0, 1'b0, 32'h0);
    add_row(STEP_CSR_RD, "reset_count", `CX_CSR_COUNT, 32'h0, 1'b0, 1'b0, 32'h0);
    add_row(STEP_ISSUE, "issue_first", 12'h0, 32'h0, 1'b1, 1'b1, 32'h0);
    add_row(STEP_IDLE, "latency_1", 12'h0, 32'h0, 1'b0, 1'b1, 32'h0);
    add_row(STEP_ISSUE, "issue_while_busy", 12'h0, 32'h0, 1'b0, 1'b1, 32'h0);
    add_row(STEP_IDLE, "latency_2", 12'h0, 32'h0, 1'b0, 1'b1, 32'h0);
    add_row(STEP_RESP, "resp_first", 12'h0, 32'h3, 1'b1, 1'b0, 32'h0);
    add_row(STEP_CSR_RD, "count_after_first", `CX_CSR_COUNT, 32'h0, 1'b0, 1'b0, 32'h1);
    add_row(STEP_CSR_RD, "status_after_first", `CX_CSR_STATUS, 32'h0, 1'b0, 1'b0, 32'h3);
    add_row(STEP_ISSUE, "issue_second", 12'h0, 32'h0, 1'b1, 1'b1, 32'h0);
    add_row(STEP_RESP, "resp_second", 12'h0, 32'hc, 1'b1, 1'b0, 32'h0);
    add_row(STEP_CSR_RD, "status_sticky_or", `CX_CSR_STATUS, 32'h0, 1'b0, 1'b0, 32'hf);
    add_row(STEP_CSR_RD, "count_after_second", `CX_CSR_COUNT, 32'h0, 1'b0, 1'b0, 32'h2);
    add_row(STEP_CSR_WR, "status_clear", `CX_CSR_STATUS, 32'h0, 1'b0, 1'b0, 32'h0);
    add_row(STEP_CSR_RD, "status_cleared", `CX_CSR_STATUS, 32'h0, 1'b0, 1'b0, 32'h0);
    add_row(STEP_RESP, "resp_while_idle", 12'h0, 32'hf, 1'b0, 1'b0, 32'h0);
    add_row(STEP_CSR_RD, "count_after_idle_resp", `CX_CSR_COUNT, 32'h0, 1'b0, 1'b0, 32'h2);
    add_row(STEP_CSR_RD, "status_after_idle_resp", `CX_CSR_STATUS, 32'h0, 1'b0, 1'b0, 32'h0);
    add_row(STEP_CSR_WR, "selector_write", `CX_CSR_SELECTOR, 32'hbeef_000e, 1'b0, 1'b0, 32'h0);
    add_row(STEP_CSR_RD, "selector_readback", `CX_CSR_SELECTOR, 32'h0, 1'b0, 1'b0, 32'hbeef_000e);
    add_row(STEP_CSR_RD, "unknown_address", 12'h7ff, 32'h0, 1'b0, 1'b0, 32'h0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    row_t                                row;
    logic [31:0]                         rnd;
    logic                                exp_req;
    logic                                exp_res;
    logic [`CX_VSTATE_W+2*`CX_ID_W-1:0] sel_ref;
    logic [`CX_VSTATE_W+2*`CX_ID_W-1:0] sel_act;

    issue_valid_i = 1'b0;
    issue_func_i  = '0;
    issue_op_a_i  = '0;
    issue_op_b_i  = '0;
    resp_valid_i  = 1'b0;
    resp_data_i   = '0;
    resp_status_i = '0;
    csr_we_i      = 1'b0;
    csr_addr_i    = '0;
    csr_wdata_i   = '0;
    n_rows        = 0;
    errors        = 0;
    lfsr_state    = LFSR_SEED;
    have_payload  = 1'b0;
    have_result   = 1'b0;
    sel_exp       = '0;
    build_table();
    if (n_rows != NUM_ROWS) begin
      $display("Stimulus table holds %0d rows instead of %0d", n_rows, NUM_ROWS);
      errors++;
    end

    @(posedge rst_ni);
    @(negedge clk_i);
    for (int unsigned i = 0; i < NUM_ROWS; i++) begin
      row = rows[i];
      case (row.kind)
        STEP_ISSUE: begin
          draw_bits(`CX_FUNC_W, rnd);
          issue_func_i = rnd[`CX_FUNC_W-1:0];
          draw_bits(`CX_DATA_W, rnd);
          issue_op_a_i = rnd;
          draw_bits(`CX_DATA_W, rnd);
          issue_op_b_i  = rnd;
          issue_valid_i = 1'b1;
          if (row.exp_pulse) begin
            exp_func     = issue_func_i;
            exp_op_a     = issue_op_a_i;
            exp_op_b     = issue_op_b_i;
            have_payload = 1'b1;
          end
        end
        STEP_RESP: begin
          draw_bits(`CX_DATA_W, rnd);
          resp_data_i   = rnd;
          resp_status_i = row.data[`CX_STATUS_W-1:0];
          resp_valid_i  = 1'b1;
          if (row.exp_pulse) begin
            exp_result  = rnd;
            have_result = 1'b1;
          end
        end
        STEP_CSR_WR: begin
          csr_we_i    = 1'b1;
          csr_addr_i  = row.addr;
          csr_wdata_i = row.data;
          if (row.addr == `CX_CSR_SELECTOR) sel_exp = row.data;
        end
        STEP_CSR_RD: csr_addr_i = row.addr;
        default: ;
      endcase

      @(posedge clk_i);
      @(negedge clk_i);
      issue_valid_i = 1'b0;
      resp_valid_i  = 1'b0;
      csr_we_i      = 1'b0;

      // Pulses are expected only on the row that causes them
      exp_req = (row.kind == STEP_ISSUE) && row.exp_pulse;
      exp_res = (row.kind == STEP_RESP) && row.exp_pulse;
      if (cx_req_valid_o !== exp_req) begin
        report_mismatch(row_name[i], "cx_req_valid_o", 32'(exp_req), 32'(cx_req_valid_o));
      end
      if (result_valid_o !== exp_res) begin
        report_mismatch(row_name[i], "result_valid_o", 32'(exp_res), 32'(result_valid_o));
      end
      if (busy_o !== row.exp_busy) begin
        report_mismatch(row_name[i], "busy_o", 32'(row.exp_busy), 32'(busy_o));
      end
      if (row.kind == STEP_ISSUE && have_payload) begin
        if (cx_req_func_o !== exp_func) begin
          report_mismatch(row_name[i], "cx_req_func_o", 32'(exp_func), 32'(cx_req_func_o));
        end
        if (cx_req_data0_o !== exp_op_a) begin
          report_mismatch(row_name[i], "cx_req_data0_o", exp_op_a, cx_req_data0_o);
        end
        if (cx_req_data1_o !== exp_op_b) begin
          report_mismatch(row_name[i], "cx_req_data1_o", exp_op_b, cx_req_data1_o);
        end
      end
      if (row.kind == STEP_RESP && have_result && result_data_o !== exp_result) begin
        report_mismatch(row_name[i], "result_data_o", exp_result, result_data_o);
      end
      if (row.kind == STEP_CSR_RD && csr_rdata_o !== row.exp_val) begin
        report_mismatch(row_name[i], "csr_rdata_o", row.exp_val, csr_rdata_o);
      end
      // Virtual state id in 31:16, state id in 3:2, CXU id in 1:0
      sel_ref = {sel_exp[31:16], sel_exp[3:2], sel_exp[1:0]};
      sel_act = {cx_virt_state_id_o, cx_state_id_o, cx_cxu_id_o};
      if (sel_act !== sel_ref) begin
        report_mismatch(row_name[i], "selector outputs", 32'(sel_ref), 32'(sel_act));
      end
    end

    $display("%0d table rows applied, %0d errors", NUM_ROWS, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    $display("Watchdog expired before the stimulus table was finished");
    $display("tests failed");
    $finish;
  end

endmodule

// File: src.f
+incdir+verilog
verilog/cx_pkg.sv
verilog/cx_issue.sv
verilog/cx_csr_file.sv
verilog/cx_resp_capture.sv
verilog/cx_unit_top.sv
verification/tb_clk_gen.sv
verification/tb_cx_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the CX unit testbench with Verilator, then decide on the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -j 0 --top-module tb_cx_unit -f src.f -o sim_cx_unit \
  && ./obj_dir/sim_cx_unit > sim.log 2>&1 \
  || echo "Build or simulation did not complete"
cat sim.log 2>/dev/null
grep -q "^all tests passed$" sim.log 2>/dev/null \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
